// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_dlx
FILELIST  = project.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: hw/alu.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module alu import dlx_pkg::*; (
	input  logic [`DLX_XLEN-1:0] a,
	input  logic [`DLX_XLEN-1:0] b,
	input  alu_func_t            func,
	output logic [`DLX_XLEN-1:0] result
);

	logic signed [`DLX_XLEN-1:0] a_s;
	logic signed [`DLX_XLEN-1:0] b_s;
	logic [4:0]                  shamt;
	logic                        lt;
	logic                        eq;

	assign a_s   = a;
	assign b_s   = b;
	assign shamt = b[4:0];   // Shift by low five bits only
	assign lt    = a_s < b_s; // Signed compare
	assign eq    = a == b;

	always_comb begin
		case (func)
			FN_SLL:          result = a << shamt;
			FN_SRL:          result = a >> shamt;
			FN_SRA:          result = a_s >>> shamt;
			FN_ADD, FN_ADDU: result = a + b; // No overflow trap
			FN_SUB, FN_SUBU: result = a - b;
			FN_AND:          result = a & b;
			FN_OR:           result = a | b;
			FN_XOR:          result = a ^ b;
			FN_SEQ:          result = {{(`DLX_XLEN-1){1'b0}}, eq};
			FN_SNE:          result = {{(`DLX_XLEN-1){1'b0}}, ~eq};
			FN_SLT:          result = {{(`DLX_XLEN-1){1'b0}}, lt};
			FN_SGT:          result = {{(`DLX_XLEN-1){1'b0}}, ~lt & ~eq};
			FN_SLE:          result = {{(`DLX_XLEN-1){1'b0}}, lt | eq};
			FN_SGE:          result = {{(`DLX_XLEN-1){1'b0}}, ~lt};
			default:         result = '0; // Undefined code
		endcase
	end

endmodule

// File: hw/control.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module control import dlx_pkg::*; (
	input  logic [`DLX_XLEN-1:0] inst,
	dlx_ctrl_if.decoder          ctrl
);

	opcode_t op;

	assign op = opcode_t'(inst[31:26]); // Major opcode field

	always_comb begin
		// Defaults describe an I-type ALU op with sign-extended immediate
		ctrl.mem_wr           = 1'b0;
		ctrl.reg_wr           = 1'b0;
		ctrl.r_type           = 1'b0;
		ctrl.branch_z         = 1'b0;
		ctrl.branch_nz        = 1'b0;
		ctrl.jmp              = 1'b0;
		ctrl.jmp_r            = 1'b0;
		ctrl.imm_inst         = 1'b1; // Everything but R-type uses the immediate
		ctrl.imm_zero_extend  = 1'b0;
		ctrl.load_zero_extend = 1'b0;
		ctrl.mem_to_reg       = 1'b0;
		ctrl.link             = 1'b0;
		ctrl.lhi              = 1'b0;
		ctrl.func_code        = FN_ADD; // Address add for loads and stores
		ctrl.mem_size         = MEM_WORD;
		case (op)
			OP_RTYPE: begin
				ctrl.r_type    = 1'b1;
				ctrl.imm_inst  = 1'b0;
				ctrl.reg_wr    = 1'b1;
				ctrl.func_code = alu_func_t'(inst[5:0]); // Function field passes through
			end
			OP_FP: begin
				ctrl.r_type   = 1'b1; // Decoded as R-type, but no writeback
				ctrl.imm_inst = 1'b0;
			end
			OP_J:    ctrl.jmp = 1'b1;
			OP_JAL: begin
				ctrl.jmp    = 1'b1;
				ctrl.link   = 1'b1;
				ctrl.reg_wr = 1'b1;
			end
			OP_JR:   ctrl.jmp_r = 1'b1;
			OP_JALR: begin
				ctrl.jmp_r  = 1'b1;
				ctrl.link   = 1'b1;
				ctrl.reg_wr = 1'b1;
			end
			OP_BEQZ: ctrl.branch_z  = 1'b1;
			OP_BNEZ: ctrl.branch_nz = 1'b1;
			OP_ADDI, OP_ADDUI, OP_SUBI, OP_SUBUI,
			OP_SLLI, OP_SRLI, OP_SRAI,
			OP_SEQI, OP_SNEI, OP_SLTI, OP_SGTI, OP_SLEI, OP_SGEI: begin
				ctrl.reg_wr = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl.reg_wr          = 1'b1;
				ctrl.imm_zero_extend = 1'b1; // Logical ops take unsigned imm
			end
			OP_LHI: begin
				ctrl.reg_wr = 1'b1;
				ctrl.lhi    = 1'b1;
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				ctrl.reg_wr     = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			OP_SB, OP_SH, OP_SW: ctrl.mem_wr = 1'b1;
			default: ;
		endcase

		case (op) // Immediate opcodes onto R-type function codes
			OP_ADDI:  ctrl.func_code = FN_ADD;
			OP_ADDUI: ctrl.func_code = FN_ADDU;
			OP_SUBI:  ctrl.func_code = FN_SUB;
			OP_SUBUI: ctrl.func_code = FN_SUBU;
			OP_ANDI:  ctrl.func_code = FN_AND;
			OP_ORI:   ctrl.func_code = FN_OR;
			OP_XORI:  ctrl.func_code = FN_XOR;
			OP_SLLI:  ctrl.func_code = FN_SLL;
			OP_SRLI:  ctrl.func_code = FN_SRL;
			OP_SRAI:  ctrl.func_code = FN_SRA;
			OP_SEQI:  ctrl.func_code = FN_SEQ;
			OP_SNEI:  ctrl.func_code = FN_SNE;
			OP_SLTI:  ctrl.func_code = FN_SLT;
			OP_SGTI:  ctrl.func_code = FN_SGT;
			OP_SLEI:  ctrl.func_code = FN_SLE;
			OP_SGEI:  ctrl.func_code = FN_SGE;
			default: ;
		endcase

		case (op) // Access size and load extension
			OP_LB, OP_SB: ctrl.mem_size = MEM_BYTE;
			OP_LH, OP_SH: ctrl.mem_size = MEM_HALF;
			OP_LBU: begin
				ctrl.mem_size         = MEM_BYTE;
				ctrl.load_zero_extend = 1'b1;
			end
			OP_LHU: begin
				ctrl.mem_size         = MEM_HALF;
				ctrl.load_zero_extend = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: hw/dlx_core.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module dlx_core (
	input  logic                 clk,
	input  logic                 rst,
	output logic [`DLX_XLEN-1:0] imem_addr,
	input  logic [`DLX_XLEN-1:0] imem_data,
	output logic [`DLX_XLEN-1:0] dmem_addr,
	output logic [`DLX_XLEN-1:0] dmem_wdata,
	output logic [3:0]           dmem_be,
	output logic                 dmem_wr,
	input  logic [`DLX_XLEN-1:0] dmem_rdata
);

	logic [`DLX_XLEN-1:0] pc;
	logic [`DLX_XLEN-1:0] pc_plus4;
	logic [`DLX_XLEN-1:0] next_pc;
	logic [`DLX_XLEN-1:0] br_target;
	logic [`DLX_XLEN-1:0] jmp_target;
	logic [`DLX_XLEN-1:0] imm_ext;
	logic [`DLX_XLEN-1:0] rs1_data;
	logic [`DLX_XLEN-1:0] rs2_data;
	logic [`DLX_XLEN-1:0] alu_b;
	logic [`DLX_XLEN-1:0] alu_result;
	logic [`DLX_XLEN-1:0] load_data;
	logic [`DLX_XLEN-1:0] wb_data;
	logic [4:0]           wb_addr;
	logic                 rs1_zero;
	logic                 br_taken;
	logic                 lsu_wr;

	dlx_ctrl_if ctrl_if ();

	control control_i (
		.inst (imem_data),
		.ctrl (ctrl_if.decoder)
	);

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `DLX_RESET_PC;
		else
			pc <= next_pc;
	end

	assign imem_addr = pc;
	assign pc_plus4  = pc + 32'd4;

	// Branch and jump offsets are relative to PC+4
	assign br_target  = pc_plus4 + {{16{imem_data[15]}}, imem_data[15:0]};
	assign jmp_target = pc_plus4 + {{6{imem_data[25]}}, imem_data[25:0]};
	assign rs1_zero   = rs1_data == '0;
	assign br_taken   = (ctrl_if.branch_z & rs1_zero) | (ctrl_if.branch_nz & ~rs1_zero);

	always_comb begin
		if (ctrl_if.jmp_r)
			next_pc = rs1_data; // JR, JALR
		else if (ctrl_if.jmp)
			next_pc = jmp_target;
		else if (br_taken)
			next_pc = br_target;
		else
			next_pc = pc_plus4;
	end

	always_comb begin
		if (ctrl_if.lhi)
			imm_ext = {imem_data[15:0], 16'd0};
		else if (ctrl_if.imm_zero_extend)
			imm_ext = {16'd0, imem_data[15:0]};
		else
			imm_ext = {{16{imem_data[15]}}, imem_data[15:0]};
	end

	// rd for R-type, r31 for links, rt otherwise
	assign wb_addr = ctrl_if.r_type ? imem_data[15:11] :
		ctrl_if.link ? `DLX_LINK_REG : imem_data[20:16];

	regfile regfile_i (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (imem_data[25:21]),
		.rs2_addr (imem_data[20:16]),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr_en    (ctrl_if.reg_wr),
		.wr_addr  (wb_addr),
		.wr_data  (wb_data)
	);

	assign alu_b = ctrl_if.imm_inst ? imm_ext : rs2_data;

	alu alu_i (
		.a      (rs1_data),
		.b      (alu_b),
		.func   (ctrl_if.func_code),
		.result (alu_result)
	);

	load_store_unit load_store_unit_i (
		.ctrl       (ctrl_if.consumer),
		.addr       (alu_result),
		.store_data (rs2_data),
		.rdata      (dmem_rdata),
		.mem_addr   (dmem_addr),
		.wdata      (dmem_wdata),
		.be         (dmem_be),
		.wr         (lsu_wr),
		.load_data  (load_data)
	);

	assign dmem_wr = lsu_wr & ~rst; // No store while PC is held in reset

	always_comb begin
		if (ctrl_if.link)
			wb_data = pc_plus4; // Return address
		else if (ctrl_if.mem_to_reg)
			wb_data = load_data;
		else if (ctrl_if.lhi)
			wb_data = imm_ext;
		else
			wb_data = alu_result;
	end

endmodule

// File: hw/dlx_ctrl_if.sv
`timescale 1ns/1ns

interface dlx_ctrl_if import dlx_pkg::*; ();

	logic      mem_wr;           // Store
	logic      reg_wr;           // Register writeback
	logic      r_type;           // Dest is rd
	logic      branch_z;         // BEQZ
	logic      branch_nz;        // BNEZ
	logic      jmp;              // J, JAL
	logic      jmp_r;            // JR, JALR
	logic      imm_inst;         // ALU b from immediate
	logic      imm_zero_extend;  // Logical immediates
	logic      load_zero_extend; // LBU, LHU
	logic      mem_to_reg;       // Load writeback
	logic      link;             // Write PC+4 to r31
	logic      lhi;              // Immediate to upper half
	alu_func_t func_code;
	mem_size_t mem_size;

	modport decoder (
		output mem_wr, reg_wr, r_type, branch_z, branch_nz, jmp, jmp_r,
		output imm_inst, imm_zero_extend, load_zero_extend, mem_to_reg,
		output link, lhi, func_code, mem_size
	);

	modport consumer (
		input mem_wr, reg_wr, r_type, branch_z, branch_nz, jmp, jmp_r,
		input imm_inst, imm_zero_extend, load_zero_extend, mem_to_reg,
		input link, lhi, func_code, mem_size
	);

endinterface

// File: hw/dlx_params.svh
`ifndef DLX_PARAMS_SVH
`define DLX_PARAMS_SVH

// Datapath and address width
`define DLX_XLEN 32

// First fetch address after reset
`define DLX_RESET_PC 32'h0000_0000

// Link target of JAL and JALR
`define DLX_LINK_REG 5'd31

// Integer register count
`define DLX_NUM_REGS 32

`endif

// File: hw/dlx_pkg.sv
package dlx_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00, // Integer ALU, func in low bits
		OP_FP    = 6'h01, // Floating point, no-op here
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQZ  = 6'h04,
		OP_BNEZ  = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ADDUI = 6'h09,
		OP_SUBI  = 6'h0a,
		OP_SUBUI = 6'h0b,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_XORI  = 6'h0e,
		OP_LHI   = 6'h0f,
		OP_JR    = 6'h12,
		OP_JALR  = 6'h13,
		OP_SLLI  = 6'h14,
		OP_SRLI  = 6'h16,
		OP_SRAI  = 6'h17,
		OP_SEQI  = 6'h18,
		OP_SNEI  = 6'h19,
		OP_SLTI  = 6'h1a,
		OP_SGTI  = 6'h1b,
		OP_SLEI  = 6'h1c,
		OP_SGEI  = 6'h1d,
		OP_LB    = 6'h20,
		OP_LH    = 6'h21,
		OP_LW    = 6'h23,
		OP_LBU   = 6'h24,
		OP_LHU   = 6'h25,
		OP_SB    = 6'h28,
		OP_SH    = 6'h29,
		OP_SW    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h04,
		FN_SRL  = 6'h06,
		FN_SRA  = 6'h07,
		FN_ADD  = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB  = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SEQ  = 6'h28,
		FN_SNE  = 6'h29,
		FN_SLT  = 6'h2a,
		FN_SGT  = 6'h2b,
		FN_SLE  = 6'h2c,
		FN_SGE  = 6'h2d
	} alu_func_t;

	// Access size of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_t;

endpackage

// File: hw/load_store_unit.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module load_store_unit import dlx_pkg::*; (
	dlx_ctrl_if.consumer         ctrl,
	input  logic [`DLX_XLEN-1:0] addr,
	input  logic [`DLX_XLEN-1:0] store_data,
	input  logic [`DLX_XLEN-1:0] rdata,
	output logic [`DLX_XLEN-1:0] mem_addr,
	output logic [`DLX_XLEN-1:0] wdata,
	output logic [3:0]           be,
	output logic                 wr,
	output logic [`DLX_XLEN-1:0] load_data
);

	logic [1:0]  offset;
	logic [7:0]  lane_b;
	logic [15:0] lane_h;

	assign offset   = addr[1:0];
	assign mem_addr = {addr[`DLX_XLEN-1:2], 2'b00}; // Word aligned, misalignment truncated
	assign wr       = ctrl.mem_wr;

	// Store lanes, big-endian so be[3] is bits 31:24
	always_comb begin
		case (ctrl.mem_size)
			MEM_BYTE: begin
				wdata = {4{store_data[7:0]}}; // Byte on every lane
				be    = 4'b1000 >> offset;
			end
			MEM_HALF: begin
				wdata = {2{store_data[15:0]}};
				be    = offset[1] ? 4'b0011 : 4'b1100;
			end
			default: begin
				wdata = store_data;
				be    = 4'b1111;
			end
		endcase
	end

	// Load lane pick
	always_comb begin
		case (offset)
			2'd0:    lane_b = rdata[31:24];
			2'd1:    lane_b = rdata[23:16];
			2'd2:    lane_b = rdata[15:8];
			default: lane_b = rdata[7:0];
		endcase
		lane_h = offset[1] ? rdata[15:0] : rdata[31:16];
	end

	always_comb begin
		case (ctrl.mem_size)
			MEM_BYTE: begin
				if (ctrl.load_zero_extend)
					load_data = {24'd0, lane_b}; // LBU
				else
					load_data = {{24{lane_b[7]}}, lane_b};
			end
			MEM_HALF: begin
				if (ctrl.load_zero_extend)
					load_data = {16'd0, lane_h}; // LHU
				else
					load_data = {{16{lane_h[15]}}, lane_h};
			end
			default: load_data = rdata;
		endcase
	end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic [4:0]          rs1_addr,
	input  logic [4:0]          rs2_addr,
	output logic [`DLX_XLEN-1:0] rs1_data,
	output logic [`DLX_XLEN-1:0] rs2_data,
	input  logic                wr_en,
	input  logic [4:0]          wr_addr,
	input  logic [`DLX_XLEN-1:0] wr_data
);

	logic [`DLX_XLEN-1:0] regs [`DLX_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DLX_NUM_REGS; i++) begin
				regs[i] <= '0; // Whole file cleared
			end
		end else if (wr_en && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data; // r0 writes dropped
		end
	end

	// Async reads, r0 forced to zero
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: project.f
+incdir+hw
hw/dlx_pkg.sv
hw/dlx_ctrl_if.sv
hw/control.sv
hw/regfile.sv
hw/alu.sv
hw/load_store_unit.sv
hw/dlx_core.sv
test/dlx_checker.sv
test/tb_dlx.sv

// File: test/dlx_checker.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module dlx_checker (
	input logic                 clk,
	input logic                 rst,
	input logic [`DLX_XLEN-1:0] imem_addr,
	input logic [`DLX_XLEN-1:0] dmem_addr,
	input logic [3:0]           dmem_be,
	input logic                 dmem_wr
);

	// No store may issue while the core is in reset
	rst_no_store: assert property (@(posedge clk) rst |-> !dmem_wr)
		else $error("store strobe high during reset");

	// Fetch restarts at the reset vector
	rst_fetch: assert property (@(posedge clk) rst |=> (imem_addr == `DLX_RESET_PC))
		else $error("fetch address after reset is not the reset vector");

	store_shape: assert property (@(posedge clk) disable iff (rst)
		dmem_wr |-> (dmem_be != 4'b0000) && (dmem_addr[1:0] == 2'b00))
		else $error("store with empty byte enables or unaligned word address");

	// Only checked once the PC holds a known value
	pc_align: assert property (@(posedge clk)
		!$isunknown(imem_addr) |-> (imem_addr[1:0] == 2'b00))
		else $error("fetch address not word aligned");

endmodule

// File: test/tb_dlx.sv
`timescale 1ns/1ns
`include "dlx_params.svh"

module tb_dlx import dlx_pkg::*; ();

	localparam int TEST_CYCLES = 45 + 45 + 20 + 45 + 15 + 15 + 20; // Per-test budgets
	localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

	logic                 clk;
	logic                 rst;
	logic [`DLX_XLEN-1:0] imem_addr;
	logic [`DLX_XLEN-1:0] imem_data;
	logic [`DLX_XLEN-1:0] dmem_addr;
	logic [`DLX_XLEN-1:0] dmem_wdata;
	logic [3:0]           dmem_be;
	logic                 dmem_wr;
	logic [`DLX_XLEN-1:0] dmem_rdata;

	logic [`DLX_XLEN-1:0] imem [64];
	logic [`DLX_XLEN-1:0] dmem [64];
	logic [31:0]          lfsr = 32'd20; // Seed
	int                   prog_len;
	int                   cycle_cnt = 0;

	alu_func_t rfns [16] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
		FN_OR, FN_XOR, FN_SEQ, FN_SNE, FN_SLT, FN_SGT, FN_SLE, FN_SGE};
	opcode_t   iops [16] = '{OP_ADDI, OP_ADDUI, OP_SUBI, OP_SUBUI, OP_ANDI, OP_ORI, OP_XORI,
		OP_SLLI, OP_SRLI, OP_SRAI, OP_SEQI, OP_SNEI, OP_SLTI, OP_SGTI, OP_SLEI, OP_SGEI};
	alu_func_t ifns [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_SLL, FN_SRL, FN_SRA, FN_SEQ, FN_SNE, FN_SLT, FN_SGT, FN_SLE, FN_SGE};

	dlx_core dlx_core_i (.*);

	bind dlx_core dlx_checker dlx_checker_i (.clk(clk), .rst(rst), .imem_addr(imem_addr),
		.dmem_addr(dmem_addr), .dmem_be(dmem_be), .dmem_wr(dmem_wr));

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	assign imem_data  = imem[imem_addr[7:2]]; // Async fetch
	assign dmem_rdata = dmem[dmem_addr[7:2]];

	always @(posedge clk) begin
		if (dmem_wr) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_be[b])
					dmem[dmem_addr[7:2]][8*b+7 -: 8] <= dmem_wdata[8*b+7 -: 8]; // Per-lane write
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the tests ran longer than %0d clock cycles", CYCLE_LIMIT);
			$display("Something failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r    = {r[30:0], lfsr[0]}; // One step per bit
		end
		return r;
	endfunction

	function automatic logic [31:0] enc_r(alu_func_t f, logic [4:0] rs1, logic [4:0] rs2,
		logic [4:0] rd);
		return {OP_RTYPE, rs1, rs2, rd, 5'd0, f};
	endfunction

	function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rs1, logic [4:0] rd,
		logic [15:0] imm);
		return {op, rs1, rd, imm};
	endfunction

	function automatic logic [31:0] enc_j(opcode_t op, logic [25:0] off);
		return {op, off};
	endfunction

	function automatic logic [31:0] fill_word(int i);
		return 32'h9E37_79B9 * 32'(i + 1); // Differs for every word
	endfunction

	function automatic logic [31:0] put_lane(logic [31:0] w, int k, logic [7:0] b);
		w[31-8*k -: 8] = b; // Lane 0 is the MSB byte
		return w;
	endfunction

	// Reference ALU from the DLX function rules
	function automatic logic [31:0] alu_model(alu_func_t f, logic [31:0] a, logic [31:0] b);
		logic lt;
		lt = $signed(a) < $signed(b);
		case (f)
			FN_SLL:          return a << b[4:0];
			FN_SRL:          return a >> b[4:0];
			FN_SRA:          return $unsigned($signed(a) >>> b[4:0]);
			FN_ADD, FN_ADDU: return a + b;
			FN_SUB, FN_SUBU: return a - b;
			FN_AND:          return a & b;
			FN_OR:           return a | b;
			FN_XOR:          return a ^ b;
			FN_SEQ:          return {31'd0, a == b};
			FN_SNE:          return {31'd0, a != b};
			FN_SLT:          return {31'd0, lt};
			FN_SGT:          return {31'd0, !lt && (a != b)};
			FN_SLE:          return {31'd0, lt || (a == b)};
			FN_SGE:          return {31'd0, !lt};
			default:         return '0;
		endcase
	endfunction

	task automatic compare_word(string what, logic [`DLX_XLEN-1:0] got,
		logic [`DLX_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic compare_pc(string what, logic [`DLX_XLEN-1:0] got, logic [`DLX_XLEN-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns: %s, fetch address %h, expected %h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	// Hold reset, then refill memories; unused words are self-loops
	task automatic begin_program();
		@(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < 64; i++) begin
			imem[i] = enc_j(OP_J, -26'sd4); // J to itself
			dmem[i] = fill_word(i);
		end
		prog_len = 0;
	endtask

	task automatic start_program();
		repeat (2) @(posedge clk); // Two reset edges
		rst <= 1'b0;
		@(negedge clk); // PC 0 showing
	endtask

	task automatic emit(logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	task automatic place(int addr, logic [31:0] w);
		imem[addr / 4] = w;
	endtask

	task automatic load_const(logic [4:0] rd, logic [31:0] v);
		emit(enc_i(OP_LHI, 5'd0, rd, v[31:16]));
		emit(enc_i(OP_ORI, rd, rd, v[15:0])); // ORI zero-extends
	endtask

	task automatic advance(int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic test_alu_rtype();
		logic [31:0] a;
		logic [31:0] b;
		a = rand_bits(32);
		b = rand_bits(32);
		begin_program();
		load_const(5'd1, a);
		load_const(5'd2, b);
		for (int k = 0; k < 16; k++) begin
			emit(enc_r(rfns[k], 5'd1, 5'd2, 5'd3));
			emit(enc_i(OP_SW, 5'd0, 5'd3, 16'(4 * k)));
		end
		start_program();
		advance(prog_len + 1);
		for (int k = 0; k < 16; k++)
			compare_word($sformatf("R-type %s", rfns[k].name()), dmem[k], alu_model(rfns[k], a, b));
	endtask

	task automatic test_alu_imm();
		logic [31:0] a;
		logic [15:0] imm [16];
		logic [31:0] ext;
		a = rand_bits(32);
		begin_program();
		load_const(5'd1, a);
		for (int k = 0; k < 16; k++) begin
			imm[k] = 16'(rand_bits(16));
			emit(enc_i(iops[k], 5'd1, 5'd3, imm[k]));
			emit(enc_i(OP_SW, 5'd0, 5'd3, 16'(4 * k)));
		end
		start_program();
		advance(prog_len + 1);
		for (int k = 0; k < 16; k++) begin
			if (iops[k] inside {OP_ANDI, OP_ORI, OP_XORI})
				ext = {16'd0, imm[k]}; // Logical immediates zero-extend
			else
				ext = {{16{imm[k][15]}}, imm[k]};
			compare_word($sformatf("immediate %s", iops[k].name()), dmem[k],
				alu_model(ifns[k], a, ext));
		end
	endtask

	task automatic test_imm_extend();
		begin_program();
		load_const(5'd4, 32'h1234_5678);
		emit(enc_i(OP_ADDI, 5'd0, 5'd2, 16'hFFF0));
		emit(enc_i(OP_ANDI, 5'd4, 5'd5, 16'h8F0F));
		emit(enc_i(OP_ORI, 5'd4, 5'd6, 16'h8001));
		emit(enc_i(OP_XORI, 5'd4, 5'd7, 16'hFFFF));
		emit(enc_i(OP_LHI, 5'd0, 5'd8, 16'h8765));
		emit(enc_i(OP_SW, 5'd0, 5'd2, 16'h0000));
		for (int k = 1; k < 5; k++)
			emit(enc_i(OP_SW, 5'd0, 5'(4 + k), 16'(4 * k)));
		start_program();
		advance(prog_len + 1);
		compare_word("ADDI sign extension", dmem[0], 32'hFFFF_FFF0);
		compare_word("ANDI zero extension", dmem[1], 32'h1234_5678 & 32'h0000_8F0F);
		compare_word("ORI zero extension", dmem[2], 32'h1234_5678 | 32'h0000_8001);
		compare_word("XORI zero extension", dmem[3], 32'h1234_5678 ^ 32'h0000_FFFF);
		compare_word("LHI upper half", dmem[4], 32'h8765_0000);
	endtask

	task automatic test_load_store();
		logic [31:0] v;
		logic [31:0] f;
		logic [7:0]  b;
		logic [15:0] h;
		v = 32'h8C7F_35E1; // Mixed sign bytes and halves
		begin_program();
		load_const(5'd1, v);
		for (int k = 0; k < 4; k++)
			emit(enc_i(OP_SB, 5'd0, 5'd1, 16'(32'h40 + 4 * k + k))); // Word 16+k at lane k
		emit(enc_i(OP_SH, 5'd0, 5'd1, 16'h0050));
		emit(enc_i(OP_SH, 5'd0, 5'd1, 16'h0056));
		emit(enc_i(OP_SW, 5'd0, 5'd1, 16'h0058));
		for (int k = 0; k < 4; k++) begin
			emit(enc_i(OP_LB, 5'd0, 5'd4, 16'(32'h58 + k)));
			emit(enc_i(OP_SW, 5'd0, 5'd4, 16'(32'h80 + 4 * k)));
			emit(enc_i(OP_LBU, 5'd0, 5'd4, 16'(32'h58 + k)));
			emit(enc_i(OP_SW, 5'd0, 5'd4, 16'(32'h90 + 4 * k)));
		end
		for (int k = 0; k < 2; k++) begin
			emit(enc_i(OP_LH, 5'd0, 5'd4, 16'(32'h58 + 2 * k)));
			emit(enc_i(OP_SW, 5'd0, 5'd4, 16'(32'hA0 + 4 * k)));
			emit(enc_i(OP_LHU, 5'd0, 5'd4, 16'(32'h58 + 2 * k)));
			emit(enc_i(OP_SW, 5'd0, 5'd4, 16'(32'hA8 + 4 * k)));
		end
		start_program();
		advance(prog_len + 1);
		for (int k = 0; k < 4; k++)
			compare_word($sformatf("SB lane %0d", k), dmem[16 + k],
				put_lane(fill_word(16 + k), k, v[7:0]));
		f = fill_word(20);
		compare_word("SH upper half", dmem[20], {v[15:0], f[15:0]});
		f = fill_word(21);
		compare_word("SH lower half", dmem[21], {f[31:16], v[15:0]});
		compare_word("SW word", dmem[22], v);
		for (int k = 0; k < 4; k++) begin
			b = v[31-8*k -: 8];
			compare_word($sformatf("LB lane %0d", k), dmem[32 + k], {{24{b[7]}}, b});
			compare_word($sformatf("LBU lane %0d", k), dmem[36 + k], {24'd0, b});
		end
		for (int k = 0; k < 2; k++) begin
			h = k ? v[15:0] : v[31:16];
			compare_word($sformatf("LH half %0d", k), dmem[40 + k], {{16{h[15]}}, h});
			compare_word($sformatf("LHU half %0d", k), dmem[42 + k], {16'd0, h});
		end
	endtask

	task automatic test_branches();
		int exp_pc [6] = '{4, 8, 20, 36, 40, 40};
		begin_program();
		place(0, enc_i(OP_ADDI, 5'd0, 5'd1, 16'd5));
		place(4, enc_i(OP_BEQZ, 5'd1, 5'd0, 16'd8));   // Not taken
		place(8, enc_i(OP_BNEZ, 5'd1, 5'd0, 16'd8));   // Taken to 20
		place(20, enc_i(OP_BEQZ, 5'd0, 5'd0, 16'd12)); // Taken to 36
		place(36, enc_i(OP_BNEZ, 5'd0, 5'd0, 16'd4));  // Not taken
		start_program();
		for (int k = 0; k < 6; k++) begin
			advance(1);
			compare_pc($sformatf("branch step %0d", k), imem_addr, 32'(exp_pc[k]));
		end
	endtask

	task automatic test_jumps();
		int exp_pc [9] = '{12, 24, 28, 32, 48, 52, 56, 64, 64};
		begin_program();
		place(0, enc_j(OP_J, 26'd8));
		place(12, enc_j(OP_JAL, 26'd8)); // r31 gets 16
		place(24, enc_i(OP_SW, 5'd0, 5'd31, 16'h00A0));
		place(28, enc_i(OP_ADDI, 5'd0, 5'd2, 16'd48));
		place(32, enc_i(OP_JALR, 5'd2, 5'd0, 16'd0)); // r31 gets 36
		place(48, enc_i(OP_SW, 5'd0, 5'd31, 16'h00A4));
		place(52, enc_i(OP_ADDI, 5'd0, 5'd3, 16'd64));
		place(56, enc_i(OP_JR, 5'd3, 5'd0, 16'd0));
		start_program();
		for (int k = 0; k < 9; k++) begin
			advance(1);
			compare_pc($sformatf("jump step %0d", k), imem_addr, 32'(exp_pc[k]));
		end
		compare_word("JAL link", dmem[40], 32'd16);
		compare_word("JALR link", dmem[41], 32'd36);
	endtask

	task automatic test_reset_r0();
		begin_program();
		place(0, enc_i(OP_SW, 5'd0, 5'd0, 16'h00CC)); // Store at the reset vector
		place(4, enc_i(OP_ADDI, 5'd0, 5'd0, 16'h1234));
		place(8, enc_i(OP_SW, 5'd0, 5'd0, 16'h00C8));
		start_program();
		advance(4);
		compare_word("r0 after write", dmem[50], 32'd0);
		dmem[51] = fill_word(51);
		@(posedge clk);
		rst <= 1'b1;
		advance(2); // SW at PC 0 showing in reset
		compare_pc("fetch in reset", imem_addr, `DLX_RESET_PC);
		compare_word("store strobe in reset", {31'd0, dmem_wr}, 32'd0);
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		compare_word("memory after reset", dmem[51], fill_word(51)); // SW held off
		compare_pc("restart fetch", imem_addr, `DLX_RESET_PC);
	endtask

	initial begin
		rst = 1'b1;
		test_alu_rtype();
		test_alu_imm();
		test_imm_extend();
		test_load_store();
		test_branches();
		test_jumps();
		test_reset_r0();
		$display("Everything OK");
		$finish;
	end

endmodule
